/* verilog/bbc_mem_macros.svh */
`ifndef BBC_MEM_MACROS_SVH
`define BBC_MEM_MACROS_SVH

// ============================================================
// memory geometry
// ============================================================

// core address, top bit picks the ram half
`define BBC_ADDR_W 19
// physical rom address as seen by the loader
`define BBC_LOAD_ADDR_W 18
`define BBC_DATA_W 8

// 16 KiB banks
`define BBC_BANK_LSB 14

// 14 slots of 16 KiB
`define BBC_ROM_SLOTS 14
`define BBC_ROM_BYTES 229376
`define BBC_RAM_BYTES 212992

`endif

/* verilog/bbc_bus_pkg.sv */
`include "bbc_mem_macros.svh"

package bbc_bus_pkg;

	// arbitrated command kinds
	typedef enum logic [1:0] {
		CMD_READ  = 2'd0,
		CMD_WRITE = 2'd1,
		CMD_LOAD  = 2'd2
	} cmd_op_e;

	// core side request, logical address
	typedef struct packed {
		logic [`BBC_ADDR_W-1:0] addr;
		logic                   we;
		logic [`BBC_DATA_W-1:0] wdata;
	} mem_req_t;

	// loader write, physical rom address
	typedef struct packed {
		logic [`BBC_LOAD_ADDR_W-1:0] addr;
		logic [`BBC_DATA_W-1:0]      data;
	} load_req_t;

	// one command into the store
	typedef struct packed {
		cmd_op_e                op;
		logic [`BBC_ADDR_W-1:0] addr;
		logic [`BBC_DATA_W-1:0] data;
	} mem_cmd_t;

	// read data back to the core
	typedef struct packed {
		logic [`BBC_DATA_W-1:0] rdata;
	} mem_rsp_t;

endpackage

/* verilog/bbc_rom_pkg.sv */
`include "bbc_mem_macros.svh"

package bbc_rom_pkg;

	// width of a physical slot number
	localparam int ROM_SLOT_W = $clog2(`BBC_ROM_SLOTS);

	// machine model, latched while loading
	typedef enum logic {
		MODEL_B      = 1'b0,
		MODEL_MASTER = 1'b1
	} model_e;

	// ============================================================
	// physical rom slots, in load image order
	// ============================================================

	typedef enum logic [ROM_SLOT_W-1:0] {
		// model b set
		IMG_OS12       = 4'd0,
		IMG_SWMMFS     = 4'd1,
		IMG_RAM_MASTER = 4'd2,
		IMG_BASIC2     = 4'd3,
		// master 128 set
		IMG_ADFS157    = 4'd4,
		IMG_MAMMFS     = 4'd5,
		IMG_MOS        = 4'd6,
		IMG_DFS        = 4'd7,
		IMG_VIEWSHT    = 4'd8,
		IMG_EDIT       = 4'd9,
		IMG_BASIC4     = 4'd10,
		IMG_ADFS       = 4'd11,
		IMG_VIEW       = 4'd12,
		IMG_TERMINAL   = 4'd13
	} rom_image_e;

	// slots 14 and 15 never hold an image
	// the bank map reports those banks as misses

endpackage

/* verilog/mem_arbiter.sv */
`timescale 1ns/1ps
`include "bbc_mem_macros.svh"

module mem_arbiter
	import bbc_bus_pkg::*;
(
	input  logic      clk_sys,
	input  logic      arst_n,
	input  logic      core_valid,
	input  mem_req_t  core_req,
	output logic      core_ready,
	input  logic      load_valid,
	input  load_req_t load_req,
	output logic      load_ready,
	output logic      cmd_valid,
	output mem_cmd_t  cmd
);

	logic     load_fire;
	logic     core_fire;
	mem_cmd_t cmd_next;

	// loader always wins, core waits it out
	assign load_ready = 1'b1;
	assign core_ready = ~load_valid;

	assign load_fire = load_valid & load_ready;
	assign core_fire = core_valid & core_ready;

	// winner select
	always_comb begin
		if (load_fire) begin
			cmd_next.op   = CMD_LOAD;
			// physical address, zero extended
			cmd_next.addr = `BBC_ADDR_W'(load_req.addr);
			cmd_next.data = load_req.data;
		end else begin
			cmd_next.op   = core_req.we ? CMD_WRITE : CMD_READ;
			cmd_next.addr = core_req.addr;
			cmd_next.data = core_req.wdata;
		end
	end

	// command valid, one per accepted request
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cmd_valid <= 1'b0;
		end else begin
			cmd_valid <= load_fire | core_fire;
		end
	end

	// payload only moves on acceptance
	always_ff @(posedge clk_sys) begin
		if (load_fire | core_fire) begin
			cmd <= cmd_next;
		end
	end

endmodule

/* verilog/rom_bank_map.sv */
`timescale 1ns/1ps
`include "bbc_mem_macros.svh"

module rom_bank_map
	import bbc_bus_pkg::*;
	import bbc_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       cmd_valid,
	input  mem_cmd_t   cmd,
	input  model_e     model_sel,
	output rom_image_e slot,
	output logic       slot_hit
);

	model_e     model_q;
	logic [3:0] bank;

	// ============================================================
	// model register
	// ============================================================

	// captured during loading only
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			model_q <= MODEL_B;
		end else if (cmd_valid && cmd.op == CMD_LOAD) begin
			model_q <= model_sel;
		end
	end

	// logical bank, addr 17..14
	assign bank = cmd.addr[`BBC_BANK_LSB+3:`BBC_BANK_LSB];

	// ============================================================
	// bank to slot lookup
	// ============================================================

	always_comb begin
		slot     = IMG_OS12;
		slot_hit = 1'b1;
		case ({model_q, bank})
			// model b
			{MODEL_B, 4'd4}:       slot = IMG_OS12;
			{MODEL_B, 4'd8}:       slot = IMG_SWMMFS;
			{MODEL_B, 4'd14}:      slot = IMG_RAM_MASTER;
			{MODEL_B, 4'd15}:      slot = IMG_BASIC2;
			// master 128
			{MODEL_MASTER, 4'd2}:  slot = IMG_ADFS157;
			{MODEL_MASTER, 4'd3}:  slot = IMG_MAMMFS;
			{MODEL_MASTER, 4'd4}:  slot = IMG_MOS;
			{MODEL_MASTER, 4'd9}:  slot = IMG_DFS;
			{MODEL_MASTER, 4'd10}: slot = IMG_VIEWSHT;
			{MODEL_MASTER, 4'd11}: slot = IMG_EDIT;
			{MODEL_MASTER, 4'd12}: slot = IMG_BASIC4;
			{MODEL_MASTER, 4'd13}: slot = IMG_ADFS;
			{MODEL_MASTER, 4'd14}: slot = IMG_VIEW;
			{MODEL_MASTER, 4'd15}: slot = IMG_TERMINAL;
			// empty socket
			default: begin
				slot     = IMG_OS12;
				slot_hit = 1'b0;
			end
		endcase
	end

endmodule

/* verilog/sideways_store.sv */
`timescale 1ns/1ps
`include "bbc_mem_macros.svh"

module sideways_store
	import bbc_bus_pkg::*;
	import bbc_rom_pkg::*;
(
	input  logic       clk_sys,
	input  logic       arst_n,
	input  logic       cmd_valid,
	input  mem_cmd_t   cmd,
	input  rom_image_e slot,
	input  logic       slot_hit,
	output logic       rsp_valid,
	output mem_rsp_t   rsp
);

	// bit 18 of the core address
	localparam int RAM_SEL = `BBC_ADDR_W - 1;

	logic [`BBC_DATA_W-1:0]      rom_mem [`BBC_ROM_BYTES];
	logic [`BBC_DATA_W-1:0]      ram_mem [`BBC_RAM_BYTES];
	logic [`BBC_LOAD_ADDR_W-1:0] rom_rd_addr;
	logic [`BBC_LOAD_ADDR_W-1:0] ram_addr;
	logic                        is_ram;

	// slot base plus offset in bank
	assign rom_rd_addr = {slot, cmd.addr[`BBC_BANK_LSB-1:0]};
	assign ram_addr    = cmd.addr[`BBC_LOAD_ADDR_W-1:0];
	assign is_ram      = cmd.addr[RAM_SEL];

	// ============================================================
	// write path
	// ============================================================

	// loader fills rom at the physical address
	always_ff @(posedge clk_sys) begin
		if (cmd_valid && cmd.op == CMD_LOAD) begin
			rom_mem[cmd.addr[`BBC_LOAD_ADDR_W-1:0]] <= cmd.data;
		end
	end

	// core writes land in ram only
	// writes into rom space dropped here
	always_ff @(posedge clk_sys) begin
		if (cmd_valid && cmd.op == CMD_WRITE && is_ram) begin
			ram_mem[ram_addr] <= cmd.data;
		end
	end

	// ============================================================
	// read response
	// ============================================================

	// data two cycles after core acceptance
	always_ff @(posedge clk_sys) begin
		if (cmd_valid && cmd.op == CMD_READ) begin
			if (is_ram) begin
				rsp.rdata <= ram_mem[ram_addr];
			end else if (slot_hit) begin
				rsp.rdata <= rom_mem[rom_rd_addr];
			end else begin
				// unmapped bank reads as zero
				rsp.rdata <= '0;
			end
		end
	end

	// strobe, reads only
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= cmd_valid && cmd.op == CMD_READ;
		end
	end

endmodule

/* verilog/bbc_mem_top.sv */
`timescale 1ns/1ps

module bbc_mem_top
	import bbc_bus_pkg::*;
	import bbc_rom_pkg::*;
(
	input  logic      clk_sys,
	input  logic      arst_n,
	// core port
	input  logic      core_valid,
	input  mem_req_t  core_req,
	output logic      core_ready,
	output logic      rsp_valid,
	output mem_rsp_t  rsp,
	// loader port
	input  logic      load_valid,
	input  load_req_t load_req,
	output logic      load_ready,
	// machine model
	input  model_e    model_sel
);

	// registered command, shared by map and store
	logic       cmd_valid;
	mem_cmd_t   cmd;
	rom_image_e slot;
	logic       slot_hit;

	// ============================================================
	// request side
	// ============================================================

	mem_arbiter mem_arbiter_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.core_valid (core_valid),
		.core_req   (core_req),
		.core_ready (core_ready),
		.load_valid (load_valid),
		.load_req   (load_req),
		.load_ready (load_ready),
		.cmd_valid  (cmd_valid),
		.cmd        (cmd)
	);

	// model and bank remap
	rom_bank_map rom_bank_map_inst (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.model_sel (model_sel),
		.slot      (slot),
		.slot_hit  (slot_hit)
	);

	// ============================================================
	// storage
	// ============================================================

	sideways_store sideways_store_inst (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.cmd_valid (cmd_valid),
		.cmd       (cmd),
		.slot      (slot),
		.slot_hit  (slot_hit),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

/* tests/tb_bbc_mem.sv */
`timescale 1ns/1ps
`include "bbc_mem_macros.svh"

module tb_bbc_mem
	import bbc_bus_pkg::*;
	import bbc_rom_pkg::*;
();

	localparam int PER_SLOT = 4;
	localparam int RAM_N    = 8;
	localparam int B2B_N    = 8;
	localparam int BANK_SZ  = 1 << `BBC_BANK_LSB;
	// loads and reads of every slot plus the unmapped, ram, stall and burst traffic
	localparam int N_TXN    = 2 * 14 * PER_SLOT + 3 + 2 * RAM_N + 2 + 4 + B2B_N;
	localparam int LIMIT    = N_TXN * 10 + 200;

	logic      clk_sys;
	logic      arst_n;
	logic      core_valid;
	mem_req_t  core_req;
	logic      core_ready;
	logic      rsp_valid;
	mem_rsp_t  rsp;
	logic      load_valid;
	load_req_t load_req;
	logic      load_ready;
	model_e    model_sel;

	// reference model state
	logic [`BBC_DATA_W-1:0] ref_rom [int];
	logic [`BBC_DATA_W-1:0] ref_ram [int];
	model_e                 ref_model;
	int                     slot_off [14][PER_SLOT];
	int                     ram_addr [RAM_N];
	int                     banks_b [4]  = '{4, 8, 14, 15};
	int                     banks_m [10] = '{2, 3, 4, 9, 10, 11, 12, 13, 14, 15};

	// expected read bytes in issue order
	logic [`BBC_DATA_W-1:0] exp_q [$];
	int                     exp_cnt = 0;
	logic [`BBC_DATA_W-1:0] exp_byte = '0;
	int                     errors = 0;
	integer                 seed = 32'h38fe_0af4;

	bbc_mem_top bbc_mem_top_inst (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.core_valid (core_valid),
		.core_req   (core_req),
		.core_ready (core_ready),
		.rsp_valid  (rsp_valid),
		.rsp        (rsp),
		.load_valid (load_valid),
		.load_req   (load_req),
		.load_ready (load_ready),
		.model_sel  (model_sel)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys;
	end

	// ============================================================
	// reference model
	// ============================================================

	// logical bank to physical slot or -1 for an empty socket
	function automatic int map_bank(model_e m, int bank);
		if (m == MODEL_B) begin
			case (bank)
				4:       return 0;
				8:       return 1;
				14:      return 2;
				15:      return 3;
				default: return -1;
			endcase
		end
		case (bank)
			2:       return 4;
			3:       return 5;
			4:       return 6;
			default: return (bank >= 9) ? bank - 2 : -1;
		endcase
	endfunction

	function automatic logic [`BBC_DATA_W-1:0] expected_read(logic [`BBC_ADDR_W-1:0] addr);
		int slot;
		if (addr[`BBC_ADDR_W-1]) begin
			return ref_ram[int'(addr[`BBC_LOAD_ADDR_W-1:0])];
		end
		slot = map_bank(ref_model, int'(addr[`BBC_BANK_LSB+3:`BBC_BANK_LSB]));
		if (slot < 0) begin
			return '0;
		end
		return ref_rom[slot * BANK_SZ + int'(addr[`BBC_BANK_LSB-1:0])];
	endfunction

	// queue head mirror sampled by the assertions
	function automatic void refresh_head();
		exp_cnt  = exp_q.size();
		exp_byte = (exp_cnt > 0) ? exp_q[0] : '0;
	endfunction

	always @(posedge clk_sys) begin
		if (rsp_valid && exp_q.size() > 0) begin
			void'(exp_q.pop_front());
		end
		refresh_head();
	end

	// ============================================================
	// bus drivers
	// ============================================================

	// entered 1 ns after an edge and left 1 ns after acceptance
	task automatic load_byte(int slot, int off, logic [`BBC_DATA_W-1:0] data);
		load_valid    = 1'b1;
		load_req.addr = `BBC_LOAD_ADDR_W'(slot * BANK_SZ + off);
		load_req.data = data;
		do @(posedge clk_sys); while (!load_ready);
		ref_rom[slot * BANK_SZ + off] = data;
		ref_model = model_sel;
		#1 load_valid = 1'b0;
	endtask

	task automatic core_access(logic [`BBC_ADDR_W-1:0] addr, logic we,
			logic [`BBC_DATA_W-1:0] wdata);
		core_valid     = 1'b1;
		core_req.addr  = addr;
		core_req.we    = we;
		core_req.wdata = wdata;
		do @(posedge clk_sys); while (!core_ready);
		if (we) begin
			// rom space writes leave the model untouched
			if (addr[`BBC_ADDR_W-1]) begin
				ref_ram[int'(addr[`BBC_LOAD_ADDR_W-1:0])] = wdata;
			end
		end else begin
			exp_q.push_back(expected_read(addr));
			refresh_head();
		end
		#1 core_valid = 1'b0;
	endtask

	// ============================================================
	// checks
	// ============================================================

	a_load_ready: assert property (@(posedge clk_sys) disable iff (!arst_n) load_ready)
		else begin
			errors++;
			$display("Error at %0t: load_ready dropped", $time);
		end

	// loader traffic stalls the core
	a_core_stall: assert property (@(posedge clk_sys) disable iff (!arst_n)
			load_valid |-> !core_ready)
		else begin
			errors++;
			$display("Error at %0t: core_ready high while loading", $time);
		end

	a_no_stray_rsp: assert property (@(posedge clk_sys) disable iff (!arst_n)
			rsp_valid |-> exp_cnt > 0)
		else begin
			errors++;
			$display("Error at %0t: response with no read in flight", $time);
		end

	a_rsp_data: assert property (@(posedge clk_sys) disable iff (!arst_n)
			rsp_valid |-> rsp.rdata == exp_byte)
		else begin
			errors++;
			$display("Error at %0t: read data %h, expected %h", $time,
				$sampled(rsp.rdata), $sampled(exp_byte));
		end

	// fixed read latency
	a_rsp_latency: assert property (@(posedge clk_sys) disable iff (!arst_n)
			(core_valid && core_ready && !core_req.we) |-> ##2 rsp_valid)
		else begin
			errors++;
			$display("Error at %0t: read response not two cycles after accept", $time);
		end

	// ============================================================
	// stimulus
	// ============================================================

	initial begin
		int s;
		int i;
		logic [`BBC_ADDR_W-1:0] a;
		arst_n     = 1'b0;
		core_valid = 1'b0;
		core_req   = '0;
		load_valid = 1'b0;
		load_req   = '0;
		model_sel  = MODEL_B;
		ref_model  = MODEL_B;
		repeat (4) @(posedge clk_sys);
		#1 arst_n = 1'b1;
		// idle with nothing coming back
		repeat (3) @(posedge clk_sys);
		#1;

		// model b image
		for (s = 0; s < 4; s++) begin
			for (i = 0; i < PER_SLOT; i++) begin
				slot_off[s][i] = $random(seed) & (BANK_SZ - 1);
				load_byte(s, slot_off[s][i], $random(seed));
			end
		end
		foreach (banks_b[k]) begin
			s = map_bank(MODEL_B, banks_b[k]);
			for (i = 0; i < PER_SLOT; i++) begin
				core_access({1'b0, 4'(banks_b[k]), 14'(slot_off[s][i])}, 1'b0, '0);
			end
		end

		// master 128 image and model follow the reload
		model_sel = MODEL_MASTER;
		for (s = 4; s < 14; s++) begin
			for (i = 0; i < PER_SLOT; i++) begin
				slot_off[s][i] = $random(seed) & (BANK_SZ - 1);
				load_byte(s, slot_off[s][i], $random(seed));
			end
		end
		// model stays latched until the next load
		@(posedge clk_sys);
		#1 model_sel = MODEL_B;
		foreach (banks_m[k]) begin
			s = map_bank(MODEL_MASTER, banks_m[k]);
			for (i = 0; i < PER_SLOT; i++) begin
				core_access({1'b0, 4'(banks_m[k]), 14'(slot_off[s][i])}, 1'b0, '0);
			end
		end
		// empty sockets read zero
		core_access({1'b0, 4'd0, 14'($random(seed))}, 1'b0, '0);
		core_access({1'b0, 4'd5, 14'($random(seed))}, 1'b0, '0);
		core_access({1'b0, 4'd8, 14'($random(seed))}, 1'b0, '0);

		// sideways ram
		for (i = 0; i < RAM_N; i++) begin
			ram_addr[i] = $random(seed) & 32'h1ffff;
			core_access({1'b1, 18'(ram_addr[i])}, 1'b1, $random(seed));
		end
		for (i = 0; i < RAM_N; i++) begin
			core_access({1'b1, 18'(ram_addr[i])}, 1'b0, '0);
		end
		// a write into rom space must not stick
		a = {1'b0, 4'd4, 14'(slot_off[6][0])};
		core_access(a, 1'b1, ~expected_read(a));
		core_access(a, 1'b0, '0);

		// core waits behind the loader
		model_sel = MODEL_MASTER;
		fork
			begin
				load_byte(13, $random(seed) & (BANK_SZ - 1), $random(seed));
				load_byte(13, $random(seed) & (BANK_SZ - 1), $random(seed));
				load_byte(13, $random(seed) & (BANK_SZ - 1), $random(seed));
			end
			core_access({1'b1, 18'(ram_addr[0])}, 1'b0, '0);
		join

		// burst of mixed ram and rom reads
		for (i = 0; i < B2B_N; i++) begin
			if (i % 2 == 1) begin
				core_access({1'b1, 18'(ram_addr[i])}, 1'b0, '0);
			end else begin
				s = map_bank(MODEL_MASTER, banks_m[i]);
				core_access({1'b0, 4'(banks_m[i]), 14'(slot_off[s][i % PER_SLOT])}, 1'b0, '0);
			end
		end

		while (exp_q.size() != 0) @(posedge clk_sys);
		repeat (4) @(posedge clk_sys);
		$display("errors: %0d", errors);
		if (errors == 0) begin
			$display("Finished with no errors");
		end else begin
			$display("Finished with errors");
		end
		$finish;
	end

	// watchdog
	initial begin
		repeat (LIMIT) @(posedge clk_sys);
		$display("Timeout: the run did not complete within %0d cycles", LIMIT);
		$display("errors: %0d", errors);
		$display("Finished with errors");
		$finish;
	end

endmodule

/* project.f */
+incdir+verilog
verilog/bbc_bus_pkg.sv
verilog/bbc_rom_pkg.sv
verilog/mem_arbiter.sv
verilog/rom_bank_map.sv
verilog/sideways_store.sv
verilog/bbc_mem_top.sv
tests/tb_bbc_mem.sv

/* Bender.yml */
package:
  name: bbc_mem

export_include_dirs:
  - verilog

sources:
  - target: rtl
    files:
      - verilog/bbc_bus_pkg.sv
      - verilog/bbc_rom_pkg.sv
  - target: rtl
    files:
      - verilog/mem_arbiter.sv
      - verilog/rom_bank_map.sv
      - verilog/sideways_store.sv
      - verilog/bbc_mem_top.sv
  - target: test
    files:
      - tests/tb_bbc_mem.sv
